// File: Makefile
# Verilator build and run for the rv_lite_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_lite_core
FILELIST  ?= rv_lite_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: include/rv_lite_defines.svh
`ifndef RV_LITE_DEFINES_SVH
`define RV_LITE_DEFINES_SVH

`define RV_XLEN       64
`define RV_ADDR_W     64
`define RV_RESET_PC   64'h0

`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011
`define RV_OP_LUI     7'b0110111
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111
`define RV_OP_TRAP    7'h6b          // custom trap, code in a0

`define RV_F3_ADD_SUB 3'b000
`define RV_F3_XOR     3'b100
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111
`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001
`define RV_F3_D       3'b011         // doubleword ld/sd

`define RV_REG_A0     5'd10

`endif

// File: logic/commit_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module commit_monitor (
	input  logic                 clock,
	input  logic                 reset,
	input  rv_lite_pkg::commit_t retire,
	output rv_lite_pkg::commit_t commit,
	output logic                 trap_valid,
	output logic [7:0]           trap_code,
	output rv_lite_pkg::xlen_t   cycle_count,
	output rv_lite_pkg::xlen_t   instr_count
);
	import rv_lite_pkg::*;

	always_ff @(posedge clock) begin
		if (reset) begin
			commit      <= '0;
			trap_valid  <= 1'b0;
			trap_code   <= 8'h00;
			cycle_count <= '0;
			instr_count <= '0;
		end else begin
			commit <= retire;            // core is halted after the trap, so valid stays low
			if (!trap_valid) begin
				cycle_count <= cycle_count + 64'd1;
				if (retire.valid)
					instr_count <= instr_count + 64'd1;    // trap counts too
				if (retire.trap) begin
					trap_valid <= 1'b1;
					trap_code  <= retire.trap_code;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_lite_defines.svh"

module exec_stage (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    fetch_valid,
	input  rv_lite_pkg::fetch_pkt_t fetch_pkt,
	output logic                    fetch_ready,
	output logic                    redirect,
	output rv_lite_pkg::addr_t      redirect_pc,
	output rv_lite_pkg::reg_idx_t   rs1_idx,
	output rv_lite_pkg::reg_idx_t   rs2_idx,
	input  rv_lite_pkg::xlen_t      rs1_data,
	input  rv_lite_pkg::xlen_t      rs2_data,
	output logic                    wr_en,
	output rv_lite_pkg::reg_idx_t   wr_idx,
	output rv_lite_pkg::xlen_t      wr_data,
	output logic                    dreq,
	output rv_lite_pkg::mem_req_t   dreq_pkt,
	input  logic                    ddone,
	input  rv_lite_pkg::xlen_t      drdata,
	output rv_lite_pkg::commit_t    retire
);
	import rv_lite_pkg::*;

	typedef enum logic [1:0] {S_READY, S_MEM, S_HALT} ex_state_e;

	ex_state_e  state;
	logic       cur_valid;
	fetch_pkt_t cur;
	logic [6:0] opcode;
	logic [2:0] funct3;
	reg_idx_t   rd;
	xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
	logic       is_imm, is_reg, is_lui, is_load, is_store, is_branch, is_jal, is_trap;
	logic       is_mem, taken, exec_now, mem_done, retiring;
	alu_op_e    alu_op;
	xlen_t      op_b, alu_res;

	assign opcode = cur.inst[6:0];
	assign funct3 = cur.inst[14:12];
	assign rd     = cur.inst[11:7];
	assign imm_i  = {{52{cur.inst[31]}}, cur.inst[31:20]};
	assign imm_s  = {{52{cur.inst[31]}}, cur.inst[31:25], cur.inst[11:7]};
	assign imm_b  = {{51{cur.inst[31]}}, cur.inst[31], cur.inst[7], cur.inst[30:25],
		cur.inst[11:8], 1'b0};
	assign imm_u  = {{32{cur.inst[31]}}, cur.inst[31:12], 12'h000};
	assign imm_j  = {{43{cur.inst[31]}}, cur.inst[31], cur.inst[19:12], cur.inst[20],
		cur.inst[30:21], 1'b0};

	assign is_imm    = (opcode == `RV_OP_IMM);
	assign is_reg    = (opcode == `RV_OP_REG);
	assign is_lui    = (opcode == `RV_OP_LUI);
	assign is_load   = (opcode == `RV_OP_LOAD) && (funct3 == `RV_F3_D);
	assign is_store  = (opcode == `RV_OP_STORE) && (funct3 == `RV_F3_D);
	assign is_branch = (opcode == `RV_OP_BRANCH);
	assign is_jal    = (opcode == `RV_OP_JAL);
	assign is_trap   = (opcode == `RV_OP_TRAP);
	assign is_mem    = is_load | is_store;

	assign rs1_idx = is_trap ? `RV_REG_A0 : cur.inst[19:15];   // trap reads a0
	assign rs2_idx = cur.inst[24:20];

	always_comb begin
		alu_op = ALU_ADD;
		if (is_lui)
			alu_op = ALU_PASS_B;
		else if (is_imm || is_reg) begin
			case (funct3)
				`RV_F3_ADD_SUB: alu_op = (is_reg && cur.inst[30]) ? ALU_SUB : ALU_ADD;
				`RV_F3_XOR:     alu_op = ALU_XOR;
				`RV_F3_OR:      alu_op = ALU_OR;
				`RV_F3_AND:     alu_op = ALU_AND;
				default:        alu_op = ALU_ADD;
			endcase
		end
	end

	assign op_b = is_reg ? rs2_data : (is_lui ? imm_u : imm_i);

	always_comb begin
		case (alu_op)
			ALU_SUB:    alu_res = rs1_data - op_b;
			ALU_AND:    alu_res = rs1_data & op_b;
			ALU_OR:     alu_res = rs1_data | op_b;
			ALU_XOR:    alu_res = rs1_data ^ op_b;
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = rs1_data + op_b;
		endcase
	end

	assign taken = is_branch && (((funct3 == `RV_F3_BEQ) && (rs1_data == rs2_data)) ||
		((funct3 == `RV_F3_BNE) && (rs1_data != rs2_data)));

	assign exec_now = cur_valid && (state == S_READY) && !is_mem;
	assign mem_done = (state == S_MEM) && ddone;
	assign retiring = exec_now | mem_done;

	assign redirect    = exec_now & (is_jal | taken);
	assign redirect_pc = cur.pc + (is_jal ? imm_j : imm_b);
	assign fetch_ready = (state != S_HALT) &
		(~cur_valid | (retiring & ~redirect & ~is_trap));   // buffer holds wrong path on redirect

	assign dreq           = (state == S_MEM) & ~ddone;
	assign dreq_pkt.addr  = rs1_data + (is_store ? imm_s : imm_i);
	assign dreq_pkt.write = is_store;
	assign dreq_pkt.wdata = rs2_data;

	assign wr_en   = retiring && (is_imm || is_reg || is_lui || is_load || is_jal) && (rd != 5'd0);
	assign wr_idx  = rd;
	assign wr_data = is_jal ? cur.pc + 64'd4 : (is_load ? drdata : alu_res);

	always_comb begin
		retire.valid     = retiring;
		retire.pc        = cur.pc;
		retire.inst      = cur.inst;
		retire.wen       = wr_en;
		retire.wdest     = rd;
		retire.wdata     = wr_data;
		retire.trap      = retiring & is_trap;
		retire.trap_code = rs1_data[7:0];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= S_READY;
			cur_valid <= 1'b0;
		end else begin
			case (state)
				S_READY: begin
					if (cur_valid && is_mem)
						state <= S_MEM;
					else if (exec_now && is_trap)
						state <= S_HALT;     // stays until reset
				end
				S_MEM:   if (ddone) state <= S_READY;
				default: state <= S_HALT;
			endcase
			if (fetch_valid && fetch_ready)
				cur_valid <= 1'b1;
			else if (retiring)
				cur_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_valid && fetch_ready)
			cur <= fetch_pkt;
	end

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_lite_defines.svh"

module fetch_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    redirect,
	input  rv_lite_pkg::addr_t      redirect_pc,
	output logic                    fetch_valid,
	input  logic                    fetch_ready,
	output rv_lite_pkg::fetch_pkt_t fetch_pkt,
	output logic                    ireq,
	output rv_lite_pkg::mem_req_t   ireq_pkt,
	input  logic                    idone,
	input  rv_lite_pkg::xlen_t      irdata
);
	import rv_lite_pkg::*;

	addr_t      pc;                 // next pc to fetch
	addr_t      req_pc;             // pc of the fetch in flight
	logic       busy;
	logic       discard;
	logic       buf_valid;
	fetch_pkt_t buf_pkt;
	logic       drain;
	logic       start;
	logic       fill;

	assign drain = buf_valid & fetch_ready;
	assign start = ~busy & ~redirect & (~buf_valid | drain);
	assign fill  = idone & ~discard & ~redirect;

	assign ireq           = busy & ~idone;
	assign ireq_pkt.addr  = {req_pc[63:3], 3'b000};    // whole doubleword
	assign ireq_pkt.write = 1'b0;
	assign ireq_pkt.wdata = '0;

	assign fetch_valid = buf_valid;
	assign fetch_pkt   = buf_pkt;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc        <= `RV_RESET_PC;
			busy      <= 1'b0;
			discard   <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			if (start)
				busy <= 1'b1;
			else if (idone)
				busy <= 1'b0;
			if (redirect) begin
				pc        <= redirect_pc;
				buf_valid <= 1'b0;
				discard   <= busy & ~idone;   // drop the stale fetch when it lands
			end else begin
				if (idone)
					discard <= 1'b0;
				if (fill) begin
					pc        <= req_pc + 64'd4;
					buf_valid <= 1'b1;
				end else if (drain)
					buf_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			req_pc <= pc;
		if (fill) begin
			buf_pkt.pc   <= req_pc;
			buf_pkt.inst <= req_pc[2] ? irdata[63:32] : irdata[31:0];
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  dreq,
	input  logic                  ireq,
	input  rv_lite_pkg::mem_req_t dreq_pkt,
	input  rv_lite_pkg::mem_req_t ireq_pkt,
	output logic                  ddone,
	output logic                  idone,
	output rv_lite_pkg::xlen_t    rdata,
	output logic                  psel,
	output logic                  penable,
	output logic                  pwrite,
	output rv_lite_pkg::addr_t    paddr,
	output rv_lite_pkg::xlen_t    pwdata,
	input  rv_lite_pkg::xlen_t    prdata,
	input  logic                  pready
);
	import rv_lite_pkg::*;

	typedef enum logic [1:0] {A_IDLE, A_SETUP, A_ACCESS} arb_state_e;

	arb_state_e state;
	logic       owner;              // 0 data, 1 fetch
	logic       done_q;
	xlen_t      rdata_q;
	mem_req_t   cur_req;

	assign cur_req = owner ? ireq_pkt : dreq_pkt;

	assign psel    = (state != A_IDLE);
	assign penable = (state == A_ACCESS);
	assign pwrite  = cur_req.write;
	assign paddr   = cur_req.addr;
	assign pwdata  = cur_req.wdata;

	assign ddone = done_q & ~owner;
	assign idone = done_q & owner;
	assign rdata = rdata_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= A_IDLE;
			owner  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				A_IDLE: begin
					if (dreq) begin          // data port first
						owner <= 1'b0;
						state <= A_SETUP;
					end else if (ireq) begin
						owner <= 1'b1;
						state <= A_SETUP;
					end
				end
				A_SETUP: state <= A_ACCESS;
				A_ACCESS: begin
					if (pready) begin
						state  <= A_IDLE;
						done_q <= 1'b1;
					end
				end
				default: state <= A_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == A_ACCESS && pready)
			rdata_q <= prdata;
	end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
	input  logic                  clock,
	input  logic                  reset,
	input  rv_lite_pkg::reg_idx_t rs1_idx,
	input  rv_lite_pkg::reg_idx_t rs2_idx,
	output rv_lite_pkg::xlen_t    rs1_data,
	output rv_lite_pkg::xlen_t    rs2_data,
	input  logic                  wr_en,
	input  rv_lite_pkg::reg_idx_t wr_idx,
	input  rv_lite_pkg::xlen_t    wr_data
);
	import rv_lite_pkg::*;

	xlen_t regs [1:31];     // x0 not stored

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_idx != 5'd0)
			regs[wr_idx] <= wr_data;
	end

	assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

// File: logic/rv_lite_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_lite_core (
	input  logic                 clock,
	input  logic                 reset,
	output logic                 psel,
	output logic                 penable,
	output logic                 pwrite,
	output rv_lite_pkg::addr_t   paddr,
	output rv_lite_pkg::xlen_t   pwdata,
	input  rv_lite_pkg::xlen_t   prdata,
	input  logic                 pready,
	output rv_lite_pkg::commit_t commit,
	output logic                 trap_valid,
	output logic [7:0]           trap_code,
	output rv_lite_pkg::xlen_t   cycle_count,
	output rv_lite_pkg::xlen_t   instr_count
);
	import rv_lite_pkg::*;

	logic       fetch_valid, fetch_ready, redirect;
	addr_t      redirect_pc;
	fetch_pkt_t fetch_pkt;
	logic       ireq, idone, dreq, ddone;
	mem_req_t   ireq_pkt, dreq_pkt;
	xlen_t      mem_rdata;             // shared by both ports
	reg_idx_t   rs1_idx, rs2_idx, wr_idx;
	xlen_t      rs1_data, rs2_data, wr_data;
	logic       wr_en;
	commit_t    retire;

	fetch_unit u_fetch (.clock(clock), .reset(reset), .redirect(redirect),
		.redirect_pc(redirect_pc), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
		.fetch_pkt(fetch_pkt), .ireq(ireq), .ireq_pkt(ireq_pkt), .idone(idone),
		.irdata(mem_rdata));

	exec_stage u_exec (.clock(clock), .reset(reset), .fetch_valid(fetch_valid),
		.fetch_pkt(fetch_pkt), .fetch_ready(fetch_ready), .redirect(redirect),
		.redirect_pc(redirect_pc), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .wr_en(wr_en), .wr_idx(wr_idx),
		.wr_data(wr_data), .dreq(dreq), .dreq_pkt(dreq_pkt), .ddone(ddone),
		.drdata(mem_rdata), .retire(retire));

	reg_file u_regs (.clock(clock), .reset(reset), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .wr_en(wr_en), .wr_idx(wr_idx),
		.wr_data(wr_data));

	mem_arbiter u_arb (.clock(clock), .reset(reset), .dreq(dreq), .ireq(ireq),
		.dreq_pkt(dreq_pkt), .ireq_pkt(ireq_pkt), .ddone(ddone), .idone(idone),
		.rdata(mem_rdata), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready));

	commit_monitor u_commit (.clock(clock), .reset(reset), .retire(retire),
		.commit(commit), .trap_valid(trap_valid), .trap_code(trap_code),
		.cycle_count(cycle_count), .instr_count(instr_count));

endmodule

`default_nettype wire

// File: logic/rv_lite_pkg.sv
`default_nettype none
`include "rv_lite_defines.svh"

package rv_lite_pkg;

	typedef logic [`RV_XLEN-1:0]   xlen_t;
	typedef logic [`RV_ADDR_W-1:0] addr_t;
	typedef logic [31:0]           inst_t;
	typedef logic [4:0]            reg_idx_t;

	typedef struct packed {
		addr_t pc;
		inst_t inst;
	} fetch_pkt_t;

	typedef struct packed {
		addr_t addr;
		logic  write;
		xlen_t wdata;
	} mem_req_t;

	// one retired instruction
	typedef struct packed {
		logic       valid;
		addr_t      pc;
		inst_t      inst;
		logic       wen;
		reg_idx_t   wdest;
		xlen_t      wdata;
		logic       trap;
		logic [7:0] trap_code;
	} commit_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B      // lui
	} alu_op_e;

endpackage

`default_nettype wire

// File: rv_lite_core.f
+incdir+include
logic/rv_lite_pkg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/mem_arbiter.sv
logic/exec_stage.sv
logic/commit_monitor.sv
logic/rv_lite_core.sv
verification/apb_mem_model.sv
verification/tb_rv_lite_core.sv

// File: verification/apb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module apb_mem_model (
	input  logic               clock,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  rv_lite_pkg::addr_t paddr,
	input  rv_lite_pkg::xlen_t pwdata,
	output rv_lite_pkg::xlen_t prdata,
	output logic               pready
);
	import rv_lite_pkg::*;

	localparam int WORDS = 256;     // 2 KiB, wraps above

	xlen_t  mem [0:WORDS-1];
	integer seed;
	int     wait_cnt;

	initial begin
		seed     = 32'h2aa266ce;
		wait_cnt = 0;
		pready   = 1'b0;
		prdata   = '0;
	end

	// everything moves on the falling edge
	always @(negedge clock) begin
		if (psel && !penable) begin
			wait_cnt = $unsigned($random(seed)) % 4;   // 0 to 3 wait states
			pready   = 1'b0;
		end else if (psel && penable && !pready) begin
			if (wait_cnt == 0) begin
				pready = 1'b1;
				if (pwrite)
					mem[paddr[10:3]] = pwdata;
				else
					prdata = mem[paddr[10:3]];
			end else
				wait_cnt = wait_cnt - 1;
		end else
			pready = 1'b0;
	end

	task automatic clear_mem();
		for (int i = 0; i < WORDS; i++)
			mem[i] = 64'hc0de_0000_0000_0000 | (xlen_t'(i) << 3);   // byte address
	endtask

	task automatic put_inst(input addr_t addr, input inst_t inst);
		if (addr[2])
			mem[addr[10:3]][63:32] = inst;
		else
			mem[addr[10:3]][31:0] = inst;
	endtask

	function automatic xlen_t peek(input addr_t addr);
		return mem[addr[10:3]];
	endfunction

endmodule

`default_nettype wire

// File: verification/tb_rv_lite_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_lite_defines.svh"

module tb_rv_lite_core;
	import rv_lite_pkg::*;

	localparam int CLOCK_PERIOD    = 10;
	localparam int TEST_COUNT      = 5;
	localparam int CYCLES_PER_TEST = 400;

	logic    clock;
	logic    reset;
	logic    psel, penable, pwrite, pready;
	addr_t   paddr;
	xlen_t   pwdata, prdata;
	commit_t commit;
	logic    trap_valid;
	logic [7:0] trap_code;
	xlen_t   cycle_count, instr_count;

	int      errors = 0;
	int      checks = 0;
	commit_t exp_q [$];
	xlen_t   xreg [0:31];            // architectural view
	addr_t   pc_at;
	logic [7:0] exp_code;

	rv_lite_core dut (.clock(clock), .reset(reset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.commit(commit), .trap_valid(trap_valid), .trap_code(trap_code),
		.cycle_count(cycle_count), .instr_count(instr_count));

	apb_mem_model mem_model (.clock(clock), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready));

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLOCK_PERIOD);
		$display("watchdog expired before all tests finished");
		$display("Something failed");
		$finish;
	end

	function automatic inst_t enc_i(input logic [6:0] op, input logic [2:0] f3,
		input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
	endfunction

	function automatic inst_t enc_s(input reg_idx_t rs2, input reg_idx_t rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, `RV_F3_D, imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic inst_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
		input reg_idx_t rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
	endfunction

	function automatic inst_t enc_j(input reg_idx_t rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
	endfunction

	function automatic string commit_str(input commit_t c);
		return $sformatf("pc=%h inst=%h wen=%b rd=%0d wdata=%h trap=%b code=%h",
			c.pc, c.inst, c.wen, c.wdest, c.wdata, c.trap, c.trap_code);
	endfunction

	task automatic check_commit(input string name, input commit_t got, input commit_t exp);
		commit_t g;
		commit_t e;
		g = got;
		e = exp;
		if (!g.wen) begin
			g.wdest = '0;
			g.wdata = '0;
		end
		if (!e.wen) begin
			e.wdest = '0;
			e.wdata = '0;
		end
		if (!g.trap)
			g.trap_code = '0;
		if (!e.trap)
			e.trap_code = '0;
		checks++;
		if (g !== e) begin
			errors++;
			$display("ERR %0t %s got %s expected %s", $time, name, commit_str(g),
				commit_str(e));
		end
	endtask

	task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic put(input inst_t inst);
		mem_model.put_inst(pc_at, inst);
		pc_at = pc_at + 64'd4;
	endtask

	// queue the expected record, update the register view, place the word
	task automatic expect_commit(input inst_t inst, input logic wen, input reg_idx_t rd,
		input xlen_t val, input logic trap);
		commit_t c;
		c = '0;
		c.valid     = 1'b1;
		c.pc        = pc_at;
		c.inst      = inst;
		c.wen       = wen;
		c.wdest     = rd;
		c.wdata     = val;
		c.trap      = trap;
		c.trap_code = xreg[`RV_REG_A0][7:0];
		exp_q.push_back(c);
		if (wen)
			xreg[rd] = val;
		put(inst);
	endtask

	task automatic do_addi(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
		expect_commit(enc_i(`RV_OP_IMM, `RV_F3_ADD_SUB, rd, rs1, imm), rd != 5'd0, rd,
			xreg[rs1] + {{52{imm[11]}}, imm}, 1'b0);
	endtask

	task automatic do_alu(input logic [2:0] f3, input logic is_sub, input reg_idx_t rd,
		input reg_idx_t rs1, input reg_idx_t rs2);
		xlen_t r;
		case (f3)
			`RV_F3_XOR: r = xreg[rs1] ^ xreg[rs2];
			`RV_F3_OR:  r = xreg[rs1] | xreg[rs2];
			`RV_F3_AND: r = xreg[rs1] & xreg[rs2];
			default:    r = is_sub ? xreg[rs1] - xreg[rs2] : xreg[rs1] + xreg[rs2];
		endcase
		expect_commit(enc_r({1'b0, is_sub, 5'b0}, rs2, rs1, f3, rd), rd != 5'd0, rd, r, 1'b0);
	endtask

	task automatic do_lui(input reg_idx_t rd, input logic [19:0] imm);
		expect_commit({imm, rd, `RV_OP_LUI}, rd != 5'd0, rd,
			{{32{imm[19]}}, imm, 12'h000}, 1'b0);
	endtask

	task automatic do_sd(input reg_idx_t rs2, input reg_idx_t rs1, input logic [11:0] imm);
		expect_commit(enc_s(rs2, rs1, imm), 1'b0, 5'd0, '0, 1'b0);
	endtask

	task automatic do_ld(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm,
		input xlen_t val);
		expect_commit(enc_i(`RV_OP_LOAD, `RV_F3_D, rd, rs1, imm), rd != 5'd0, rd, val, 1'b0);
	endtask

	// x31 counts the fall-through slots that really execute
	task automatic do_branch(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2);
		logic taken;
		taken = (f3 == `RV_F3_BEQ) ? (xreg[rs1] == xreg[rs2]) : (xreg[rs1] != xreg[rs2]);
		expect_commit(enc_b(f3, rs1, rs2, 13'd8), 1'b0, 5'd0, '0, 1'b0);
		if (taken)
			put(enc_i(`RV_OP_IMM, `RV_F3_ADD_SUB, 5'd31, 5'd31, 12'd1));
		else
			do_addi(5'd31, 5'd31, 12'd1);
	endtask

	task automatic do_jal(input reg_idx_t rd);
		expect_commit(enc_j(rd, 21'd12), rd != 5'd0, rd, pc_at + 64'd4, 1'b0);
		put(enc_i(`RV_OP_IMM, `RV_F3_ADD_SUB, 5'd30, 5'd30, 12'd1));   // skipped
		put(enc_i(`RV_OP_IMM, `RV_F3_ADD_SUB, 5'd30, 5'd30, 12'd2));
	endtask

	task automatic do_trap();
		exp_code = xreg[`RV_REG_A0][7:0];
		expect_commit({25'd0, `RV_OP_TRAP}, 1'b0, 5'd0, '0, 1'b1);
	endtask

	task automatic begin_test(input string name);
		$display("test %s", name);
		exp_q.delete();
		for (int i = 0; i < 32; i++)
			xreg[i] = '0;
		pc_at = `RV_RESET_PC;
		mem_model.clear_mem();
	endtask

	task automatic apply_reset();
		@(negedge clock);
		reset = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
	endtask

	// run until the trap, checking every commit, then watch the halted core
	task automatic run_program();
		int    seen;
		xlen_t cyc;
		seen = 0;
		apply_reset();
		while (!trap_valid) begin
			@(negedge clock);
			if (commit.valid) begin
				seen++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected commit at pc %h, no more were expected", commit.pc);
				end else
					check_commit("commit", commit, exp_q.pop_front());
			end
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("trap reached with %0d expected commits missing", exp_q.size());
		end
		check_word("trap_code", xlen_t'(trap_code), xlen_t'(exp_code));
		check_word("instr_count", instr_count, xlen_t'(seen));
		cyc = cycle_count;
		repeat (20) begin
			@(negedge clock);
			if (commit.valid) begin
				errors++;
				$display("commit at pc %h after the trap", commit.pc);
			end
		end
		check_word("cycle_count", cycle_count, cyc);
	endtask

	task automatic test_alu_lui();
		begin_test("alu_lui");
		do_lui(5'd1, 20'h12345);
		do_lui(5'd9, 20'hfffff);              // sign extends
		do_addi(5'd2, 5'd0, 12'h7ff);
		do_addi(5'd3, 5'd0, 12'hffb);         // -5
		do_alu(`RV_F3_ADD_SUB, 1'b0, 5'd4, 5'd1, 5'd2);
		do_alu(`RV_F3_ADD_SUB, 1'b1, 5'd5, 5'd3, 5'd2);
		do_alu(`RV_F3_AND, 1'b0, 5'd6, 5'd4, 5'd3);
		do_alu(`RV_F3_OR, 1'b0, 5'd7, 5'd2, 5'd9);
		do_alu(`RV_F3_XOR, 1'b0, 5'd8, 5'd4, 5'd5);
		do_addi(5'd10, 5'd8, 12'h021);
		do_trap();
		run_program();
	endtask

	task automatic test_x0();
		begin_test("x0");
		do_addi(5'd0, 5'd0, 12'd55);           // wen low
		do_alu(`RV_F3_ADD_SUB, 1'b0, 5'd11, 5'd0, 5'd0);
		do_addi(5'd12, 5'd0, 12'd3);
		do_alu(`RV_F3_OR, 1'b0, 5'd13, 5'd0, 5'd12);
		do_addi(5'd10, 5'd0, 12'd0);
		do_trap();
		run_program();
	endtask

	task automatic test_load_store();
		begin_test("load_store");
		do_addi(5'd6, 5'd0, 12'h400);
		do_lui(5'd1, 20'h89abc);
		do_addi(5'd1, 5'd1, 12'h123);
		do_addi(5'd2, 5'd0, 12'hfb3);          // -77
		do_sd(5'd1, 5'd6, 12'd0);
		do_sd(5'd2, 5'd6, 12'd8);
		do_ld(5'd3, 5'd6, 12'd0, xreg[1]);
		do_ld(5'd4, 5'd6, 12'd8, xreg[2]);
		do_alu(`RV_F3_ADD_SUB, 1'b0, 5'd10, 5'd3, 5'd4);
		do_trap();
		run_program();
		check_word("mem[0x400]", mem_model.peek(64'h400), xreg[1]);
		check_word("mem[0x408]", mem_model.peek(64'h408), xreg[2]);
	endtask

	task automatic test_branch_jal();
		begin_test("branch_jal");
		do_addi(5'd1, 5'd0, 12'd5);
		do_addi(5'd2, 5'd0, 12'd5);
		do_addi(5'd3, 5'd0, 12'd7);
		do_branch(`RV_F3_BEQ, 5'd1, 5'd2);     // taken
		do_branch(`RV_F3_BEQ, 5'd1, 5'd3);
		do_branch(`RV_F3_BNE, 5'd1, 5'd3);     // taken
		do_branch(`RV_F3_BNE, 5'd1, 5'd2);
		do_jal(5'd4);
		do_jal(5'd0);
		do_addi(5'd10, 5'd31, 12'd0);
		do_trap();
		run_program();
	endtask

	task automatic test_trap();
		begin_test("trap");
		do_lui(5'd10, 20'h12345);
		do_addi(5'd10, 5'd10, 12'h0c3);
		do_trap();
		put(enc_i(`RV_OP_IMM, `RV_F3_ADD_SUB, 5'd1, 5'd0, 12'd1));   // never retires
		put(enc_i(`RV_OP_IMM, `RV_F3_ADD_SUB, 5'd2, 5'd0, 12'd2));
		run_program();
		check_word("trap_valid", xlen_t'(trap_valid), 64'd1);
	endtask

	initial begin
		reset = 1'b1;
		test_alu_lui();
		test_x0();
		test_load_store();
		test_branch_jal();
		test_trap();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
